// ==== src/regPkg.sv ====
`default_nettype none

package regPkg;

  localparam int numRegs = 32;
  localparam int regIdxW = $clog2(numRegs);
  localparam int wordW   = 32;
  localparam int laneW   = wordW / 8;

  typedef logic [regIdxW-1:0] regIdxT;
  typedef logic [wordW-1:0]   wordT;
  // Bit 3 covers bits 31:24, big-endian lane order
  typedef logic [laneW-1:0]   laneSelT;
  // Word-granular address, used for the pc and memory words
  typedef logic [wordW-3:0]   wordAddrT;

  // Hardwired zero register
  localparam regIdxT zeroReg = '0;

endpackage

`default_nettype wire

// ==== src/opPkg.sv ====
`default_nettype none

package opPkg;

  typedef enum logic [2:0] {
    opAlu,
    opLoad,
    opStore,
    opLink,
    opRead
  } opcodeT;

  typedef enum logic [1:0] {
    szByte,
    szHalf,
    szWord
  } sizeT;

  // Write-back source for the register file
  typedef enum logic [1:0] {
    wbResult,
    wbLoad,
    wbLink
  } wbSrcT;

  typedef struct packed {
    opcodeT           opcode;
    sizeT             size;
    regPkg::regIdxT   rd;
    regPkg::regIdxT   ra;
    regPkg::regIdxT   rb;
    logic [31:0]      addr;
    regPkg::wordT     result;
    regPkg::wordAddrT pc;
  } cmdT;

  typedef struct packed {
    regPkg::wordT regA;
    regPkg::wordT regB;
  } rspT;

  typedef struct packed {
    regPkg::wordAddrT wordAddr;
    logic             we;
    regPkg::laneSelT  sel;
    regPkg::wordT     wdata;
  } memReqT;

endpackage

`default_nettype wire

// ==== src/regFileBank.sv ====
`default_nettype none
`timescale 1ns/1ps

module regFileBank (
  input  logic           gclk,
  input  logic           rstN,
  input  logic           rdEn,
  input  regPkg::regIdxT rdAddr,
  output regPkg::wordT   rdData,
  input  logic           wrEn,
  input  regPkg::regIdxT wrAddr,
  input  regPkg::wordT   wrData
);
  import regPkg::*;

  wordT mem [numRegs];

  // R0 is never stored, so the array needs no init
  always_ff @(posedge gclk) begin
    if (wrEn && (wrAddr != zeroReg)) begin
      mem[wrAddr] <= wrData;
    end
  end

  // Registered read port
  always_ff @(posedge gclk or negedge rstN) begin
    if (!rstN) begin
      rdData <= '0;
    end else if (rdEn) begin
      if (rdAddr == zeroReg) begin
        rdData <= '0;
      end else begin
        rdData <= mem[rdAddr];
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/regFile.sv ====
`default_nettype none
`timescale 1ns/1ps

module regFile (
  input  logic             gclk,
  input  logic             rstN,
  input  logic             rdEn,
  input  regPkg::regIdxT   raIdx,
  input  regPkg::regIdxT   rbIdx,
  input  regPkg::regIdxT   rdIdx,
  input  logic             wrEn,
  input  opPkg::wbSrcT     wbSrc,
  input  regPkg::wordT     result,
  input  regPkg::wordAddrT pcWord,
  input  opPkg::sizeT      size,
  input  logic [1:0]       byteOfs,
  input  regPkg::wordT     loadWord,
  output regPkg::wordT     regA,
  output regPkg::wordT     regB,
  output regPkg::wordT     storeWord,
  output regPkg::laneSelT  storeSel,
  output regPkg::laneSelT  loadSel
);
  import regPkg::*;
  import opPkg::*;

  wordT    regD;
  wordT    wbData;
  wordT    loadAligned;
  laneSelT laneSel;
  logic    misaligned;

  // All three banks share the write port, so they hold the same contents
  regFileBank bankA (
    .gclk(gclk), .rstN(rstN),
    .rdEn(rdEn), .rdAddr(raIdx), .rdData(regA),
    .wrEn(wrEn), .wrAddr(rdIdx), .wrData(wbData)
  );

  regFileBank bankB (
    .gclk(gclk), .rstN(rstN),
    .rdEn(rdEn), .rdAddr(rbIdx), .rdData(regB),
    .wrEn(wrEn), .wrAddr(rdIdx), .wrData(wbData)
  );

  // Bank D supplies store data
  regFileBank bankD (
    .gclk(gclk), .rstN(rstN),
    .rdEn(rdEn), .rdAddr(rdIdx), .rdData(regD),
    .wrEn(wrEn), .wrAddr(rdIdx), .wrData(wbData)
  );

  // Byte offset 0 is the most significant lane
  always_comb begin
    unique case (size)
      szByte:  laneSel = 4'b1000 >> byteOfs;
      szHalf:  laneSel = byteOfs[1] ? 4'b0011 : 4'b1100;
      default: laneSel = 4'b1111;
    endcase
  end

  assign loadSel  = laneSel;
  assign storeSel = laneSel;

  // Load aligner, zero-extended
  always_comb begin
    case (laneSel)
      4'b1000: loadAligned = {24'd0, loadWord[31:24]};
      4'b0100: loadAligned = {24'd0, loadWord[23:16]};
      4'b0010: loadAligned = {24'd0, loadWord[15:8]};
      4'b0001: loadAligned = {24'd0, loadWord[7:0]};
      4'b1100: loadAligned = {16'd0, loadWord[31:16]};
      4'b0011: loadAligned = {16'd0, loadWord[15:0]};
      default: loadAligned = loadWord;
    endcase
  end

  // Store replicator
  always_comb begin
    unique case (size)
      szByte:  storeWord = {4{regD[7:0]}};
      szHalf:  storeWord = {2{regD[15:0]}};
      default: storeWord = regD;
    endcase
  end

  always_comb begin
    unique case (wbSrc)
      wbLoad:  wbData = loadAligned;
      wbLink:  wbData = {pcWord, 2'b00};
      default: wbData = result;
    endcase
  end

  assign misaligned = ((size == szHalf) && byteOfs[0]) ||
                      ((size == szWord) && (byteOfs != 2'b00));

  // A load write-back must come from an aligned access
  aLoadAligned: assert property (
    @(posedge gclk) disable iff (!rstN)
    (wrEn && (wbSrc == wbLoad)) |-> !misaligned
  ) else $error("misaligned load, size %0d offset %0d", size, byteOfs);

endmodule

`default_nettype wire

// ==== src/memPort.sv ====
`default_nettype none
`timescale 1ns/1ps

module memPort #(
  parameter int memAddrBits = 8
) (
  input  logic          gclk,
  input  logic          rstN,
  input  logic          start,
  input  opPkg::memReqT reqIn,
  output logic          memReq,
  output opPkg::memReqT memOut,
  input  logic          memAck,
  input  regPkg::wordT  memRdata,
  output logic          done,
  output regPkg::wordT  rdWord
);
  import regPkg::*;

  typedef enum logic [1:0] {
    mpIdle,
    mpReq,
    mpRelease
  } mpStateT;

  mpStateT                state;
  logic [memAddrBits-1:0] addrQ;
  logic                   weQ;
  laneSelT                selQ;
  wordT                   wdataQ;

  always_ff @(posedge gclk or negedge rstN) begin
    if (!rstN) begin
      state  <= mpIdle;
      memReq <= 1'b0;
      done   <= 1'b0;
    end else begin
      done <= 1'b0;
      unique case (state)
        mpIdle: begin
          if (start) begin
            memReq <= 1'b1;
            state  <= mpReq;
          end
        end
        mpReq: begin
          if (memAck) begin
            memReq <= 1'b0;
            state  <= mpRelease;
          end
        end
        mpRelease: begin
          // Done one cycle after ack seen low
          if (!memAck) begin
            done  <= 1'b1;
            state <= mpIdle;
          end
        end
        default: state <= mpIdle;
      endcase
    end
  end

  // Request held from start until the next start
  always_ff @(posedge gclk) begin
    if ((state == mpIdle) && start) begin
      addrQ  <= reqIn.wordAddr[memAddrBits-1:0];
      weQ    <= reqIn.we;
      selQ   <= reqIn.sel;
      wdataQ <= reqIn.wdata;
    end
    if ((state == mpReq) && memAck) begin
      rdWord <= memRdata;
    end
  end

  always_comb begin
    memOut                            = '0;
    memOut.wordAddr[memAddrBits-1:0]  = addrQ;
    memOut.we                         = weQ;
    memOut.sel                        = selQ;
    memOut.wdata                      = wdataQ;
  end

  aReqStable: assert property (
    @(posedge gclk) disable iff (!rstN)
    (memReq && $past(memReq)) |-> $stable(memOut)
  ) else $error("memOut changed during memReq");

endmodule

`default_nettype wire

// ==== src/cmdSequencer.sv ====
`default_nettype none
`timescale 1ns/1ps

module cmdSequencer #(
  parameter int memAddrBits = 8
) (
  input  logic             gclk,
  input  logic             rstN,
  input  logic             cmdReq,
  input  opPkg::cmdT       cmdIn,
  output logic             cmdAck,
  output opPkg::rspT       rspOut,
  output logic             rdEn,
  output regPkg::regIdxT   raIdx,
  output regPkg::regIdxT   rbIdx,
  output regPkg::regIdxT   rdIdx,
  output logic             wrEn,
  output opPkg::wbSrcT     wbSrc,
  output regPkg::wordT     result,
  output regPkg::wordAddrT pcWord,
  output opPkg::sizeT      size,
  output logic [1:0]       byteOfs,
  output regPkg::wordT     loadWord,
  input  regPkg::wordT     storeWord,
  input  regPkg::laneSelT  storeSel,
  input  regPkg::laneSelT  loadSel,
  output logic             memStart,
  output opPkg::memReqT    memReqOut,
  input  logic             memDone,
  input  regPkg::wordT     memRdWord,
  input  regPkg::wordT     regA,
  input  regPkg::wordT     regB
);
  import opPkg::*;

  typedef enum logic [2:0] {
    sqIdle,
    sqRead,
    sqMem,
    sqWrite,
    sqAck,
    sqRelease
  } sqStateT;

  sqStateT state;
  cmdT     cmdQ;
  logic    isMemOp;
  logic    writesBack;

  assign isMemOp    = (cmdQ.opcode == opLoad) || (cmdQ.opcode == opStore);
  assign writesBack = (cmdQ.opcode == opAlu) || (cmdQ.opcode == opLoad) ||
                      (cmdQ.opcode == opLink);

  // Every command passes sqWrite, which keeps opRead at 3 cycles
  always_ff @(posedge gclk or negedge rstN) begin
    if (!rstN) begin
      state    <= sqIdle;
      cmdAck   <= 1'b0;
      memStart <= 1'b0;
    end else begin
      memStart <= 1'b0;
      unique case (state)
        sqIdle: begin
          if (cmdReq) begin
            state <= sqRead;
          end
        end
        sqRead: begin
          if (isMemOp) begin
            memStart <= 1'b1;
            state    <= sqMem;
          end else begin
            state <= sqWrite;
          end
        end
        sqMem: begin
          if (memDone) begin
            state <= sqWrite;
          end
        end
        sqWrite: state <= sqAck;
        sqAck: begin
          cmdAck <= 1'b1;
          state  <= sqRelease;
        end
        sqRelease: begin
          if (!cmdReq) begin
            cmdAck <= 1'b0;
            state  <= sqIdle;
          end
        end
        default: state <= sqIdle;
      endcase
    end
  end

  always_ff @(posedge gclk) begin
    if ((state == sqIdle) && cmdReq) begin
      cmdQ <= cmdIn;
    end
    if (state == sqAck) begin
      rspOut.regA <= regA;
      rspOut.regB <= regB;
    end
  end

  // Register file control
  assign rdEn     = (state == sqRead);
  assign wrEn     = (state == sqWrite) && writesBack;
  assign raIdx    = cmdQ.ra;
  assign rbIdx    = cmdQ.rb;
  assign rdIdx    = cmdQ.rd;
  assign result   = cmdQ.result;
  assign pcWord   = cmdQ.pc;
  assign size     = cmdQ.size;
  assign byteOfs  = cmdQ.addr[1:0];
  assign loadWord = memRdWord;

  always_comb begin
    unique case (cmdQ.opcode)
      opLoad:  wbSrc = wbLoad;
      opLink:  wbSrc = wbLink;
      default: wbSrc = wbResult;
    endcase
  end

  // Memory request, upper word address bits zero
  always_comb begin
    memReqOut                           = '0;
    memReqOut.wordAddr[memAddrBits-1:0] = cmdQ.addr[memAddrBits+1:2];
    memReqOut.we                        = (cmdQ.opcode == opStore);
    memReqOut.sel                       = memReqOut.we ? storeSel : loadSel;
    memReqOut.wdata                     = storeWord;
  end

  aAckNeedsReq: assert property (
    @(posedge gclk) disable iff (!rstN)
    $rose(cmdAck) |-> cmdReq
  ) else $error("cmdAck rose without cmdReq");

endmodule

`default_nettype wire

// ==== src/dataPathTop.sv ====
`default_nettype none
`timescale 1ns/1ps

module dataPathTop #(
  parameter int memAddrBits = 8
) (
  input  logic          gclk,
  input  logic          rstN,
  input  logic          cmdReq,
  input  opPkg::cmdT    cmdIn,
  output logic          cmdAck,
  output opPkg::rspT    rspOut,
  output logic          memReq,
  output opPkg::memReqT memOut,
  input  logic          memAck,
  input  regPkg::wordT  memRdata
);
  import regPkg::*;
  import opPkg::*;

  logic     rdEn;
  logic     wrEn;
  regIdxT   raIdx;
  regIdxT   rbIdx;
  regIdxT   rdIdx;
  wbSrcT    wbSrc;
  wordT     result;
  wordAddrT pcWord;
  sizeT     size;
  logic [1:0] byteOfs;
  wordT     loadWord;
  wordT     regA;
  wordT     regB;
  wordT     storeWord;
  laneSelT  storeSel;
  laneSelT  loadSel;
  logic     memStart;
  memReqT   memReqOut;
  logic     memDone;
  wordT     memRdWord;

  cmdSequencer #(.memAddrBits(memAddrBits)) sequencer (
    .gclk(gclk), .rstN(rstN),
    .cmdReq(cmdReq), .cmdIn(cmdIn), .cmdAck(cmdAck), .rspOut(rspOut),
    .rdEn(rdEn), .raIdx(raIdx), .rbIdx(rbIdx), .rdIdx(rdIdx),
    .wrEn(wrEn), .wbSrc(wbSrc), .result(result), .pcWord(pcWord),
    .size(size), .byteOfs(byteOfs), .loadWord(loadWord),
    .storeWord(storeWord), .storeSel(storeSel), .loadSel(loadSel),
    .memStart(memStart), .memReqOut(memReqOut),
    .memDone(memDone), .memRdWord(memRdWord),
    .regA(regA), .regB(regB)
  );

  regFile regs (
    .gclk(gclk), .rstN(rstN),
    .rdEn(rdEn), .raIdx(raIdx), .rbIdx(rbIdx), .rdIdx(rdIdx),
    .wrEn(wrEn), .wbSrc(wbSrc), .result(result), .pcWord(pcWord),
    .size(size), .byteOfs(byteOfs), .loadWord(loadWord),
    .regA(regA), .regB(regB),
    .storeWord(storeWord), .storeSel(storeSel), .loadSel(loadSel)
  );

  memPort #(.memAddrBits(memAddrBits)) mport (
    .gclk(gclk), .rstN(rstN),
    .start(memStart), .reqIn(memReqOut),
    .memReq(memReq), .memOut(memOut),
    .memAck(memAck), .memRdata(memRdata),
    .done(memDone), .rdWord(memRdWord)
  );

endmodule

`default_nettype wire

// ==== test/tbChecker.sv ====
`default_nettype none
`timescale 1ns/1ps

module tbChecker (
  input  logic          gclk,
  input  logic          rstN,
  input  logic          cmdReq,
  input  opPkg::cmdT    cmdIn,
  input  logic          cmdAck,
  input  opPkg::rspT    rspOut,
  input  logic          memReq,
  input  opPkg::memReqT memOut,
  input  logic          memAck,
  input  regPkg::wordT  memRdata,
  input  int            testIdx,
  input  logic          testEnd,
  input  logic          runEnd,
  output int            errCount
);
  import regPkg::*;
  import opPkg::*;

  // Cycles from cmdReq seen high to cmdAck for non-memory commands
  localparam int fixedLatency = 3;

  wordT     regs [32];
  wordT     mem [256];
  wordT     loadVal;
  laneSelT  expSel;
  wordT     expData;
  logic     prevAck;
  logic     prevReq;
  logic     prevMemReq;
  logic     prevMemAck;
  logic     resetChecked;
  int       reqCycles;
  int       checkCount;
  int       testErrStart;

  // Same pattern as the memory responder
  function automatic wordT fillWord(input int i);
    logic [7:0] a;
    a = i[7:0];
    fillWord = {a ^ 8'hA5, ~a, a + 8'h3C, {a[3:0], a[7:4]}};
  endfunction

  // Lane 3 is the most significant byte, offset 0
  function automatic laneSelT laneFor(input sizeT sz, input logic [1:0] ofs);
    if (sz == szByte) laneFor = 4'b0001 << (2'd3 - ofs);
    else if (sz == szHalf) laneFor = (ofs == 2'd0) ? 4'b1100 : 4'b0011;
    else laneFor = 4'b1111;
  endfunction

  function automatic wordT replicate(input sizeT sz, input wordT d);
    if (sz == szByte) replicate = {d[7:0], d[7:0], d[7:0], d[7:0]};
    else if (sz == szHalf) replicate = {d[15:0], d[15:0]};
    else replicate = d;
  endfunction

  function automatic wordT alignLoad(input sizeT sz, input logic [1:0] ofs, input wordT w);
    wordT shifted;
    shifted = w >> (8 * (3 - int'(ofs)));
    if (sz == szByte) alignLoad = {24'd0, shifted[7:0]};
    else if (sz == szHalf) alignLoad = (ofs == 2'd0) ? {16'd0, w[31:16]} : {16'd0, w[15:0]};
    else alignLoad = w;
  endfunction

  task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
    end
  endtask

  function automatic string testName(input int idx);
    case (idx)
      1: testName = "fill and read";
      2: testName = "link";
      3: testName = "store";
      4: testName = "load";
      default: testName = "random mix";
    endcase
  endfunction

  initial begin
    for (int i = 0; i < 32; i++) regs[i] = '0;
    for (int i = 0; i < 256; i++) mem[i] = fillWord(i);
    errCount = 0;
    checkCount = 0;
    testErrStart = 0;
    resetChecked = 1'b0;
    loadVal = '0;
  end

  // Everything is sampled on the falling edge, where DUT outputs are settled
  always @(negedge gclk) begin
    if (!rstN) begin
      prevAck = 1'b0;
      prevReq = 1'b0;
      prevMemReq = 1'b0;
      prevMemAck = 1'b0;
      reqCycles = 0;
    end else begin
      if (!resetChecked) begin
        checkVal("cmdAck after reset", {31'd0, cmdAck}, 32'd0);
        checkVal("memReq after reset", {31'd0, memReq}, 32'd0);
        resetChecked = 1'b1;
      end
      if (memReq && !prevMemReq) begin
        expSel = laneFor(cmdIn.size, cmdIn.addr[1:0]);
        checkVal("memOut.wordAddr", {2'b00, memOut.wordAddr}, {24'd0, cmdIn.addr[9:2]});
        checkVal("memOut.we", {31'd0, memOut.we}, {31'd0, cmdIn.opcode == opStore});
        checkVal("memOut.sel", {28'd0, memOut.sel}, {28'd0, expSel});
        if (cmdIn.opcode == opStore) begin
          expData = replicate(cmdIn.size, regs[cmdIn.rd]);
          checkVal("memOut.wdata", memOut.wdata, expData);
        end
      end
      if (memAck && !prevMemAck) begin
        if (cmdIn.opcode == opStore) begin
          for (int b = 0; b < 4; b++) begin
            if (expSel[b]) mem[cmdIn.addr[9:2]][8*b +: 8] = expData[8*b +: 8];
          end
        end else begin
          loadVal = mem[cmdIn.addr[9:2]];
          checkVal("memRdata", memRdata, loadVal);
        end
      end
      if (cmdAck && !prevAck) begin
        if ((cmdIn.opcode == opAlu) || (cmdIn.opcode == opLink) ||
            (cmdIn.opcode == opRead)) begin
          checkVal("cmdAck latency", reqCycles, fixedLatency);
        end
        case (cmdIn.opcode)
          opAlu: if (cmdIn.rd != 5'd0) regs[cmdIn.rd] = cmdIn.result;
          opLink: if (cmdIn.rd != 5'd0) regs[cmdIn.rd] = {cmdIn.pc, 2'b00};
          opLoad: begin
            if (cmdIn.rd != 5'd0) begin
              regs[cmdIn.rd] = alignLoad(cmdIn.size, cmdIn.addr[1:0], loadVal);
            end
          end
          opRead: begin
            checkVal("rspOut.regA", rspOut.regA, regs[cmdIn.ra]);
            checkVal("rspOut.regB", rspOut.regB, regs[cmdIn.rb]);
          end
          default: ;
        endcase
      end
      // Cycles since cmdReq was first seen high
      if (cmdReq && !prevReq) begin
        reqCycles = 0;
      end else if (cmdReq && !cmdAck) begin
        reqCycles++;
      end
      prevAck = cmdAck;
      prevReq = cmdReq;
      prevMemReq = memReq;
      prevMemAck = memAck;
    end
    if (testEnd) begin
      $display("test %0d %s: %0d errors", testIdx, testName(testIdx),
               errCount - testErrStart);
      testErrStart = errCount;
    end
    if (runEnd) begin
      $display("checks %0d, errors %0d", checkCount, errCount);
    end
  end

endmodule

`default_nettype wire

// ==== test/tbTop.sv ====
`default_nettype none
`timescale 1ns/1ps

module tbTop;
  import regPkg::*;
  import opPkg::*;

  localparam int ackTimeout = 200;

  logic   gclk;
  logic   rstN;
  logic   cmdReq;
  cmdT    cmdIn;
  logic   cmdAck;
  rspT    rspOut;
  logic   memReq;
  memReqT memOut;
  logic   memAck;
  wordT   memRdata;
  int     testIdx;
  logic   testEnd;
  logic   runEnd;
  int     errCount;
  integer seed;
  integer delaySeed;
  wordT   mem [256];
  int     delay;

  dataPathTop #(.memAddrBits(8)) dut (
    .gclk(gclk), .rstN(rstN),
    .cmdReq(cmdReq), .cmdIn(cmdIn), .cmdAck(cmdAck), .rspOut(rspOut),
    .memReq(memReq), .memOut(memOut), .memAck(memAck), .memRdata(memRdata)
  );

  tbChecker check (
    .gclk(gclk), .rstN(rstN),
    .cmdReq(cmdReq), .cmdIn(cmdIn), .cmdAck(cmdAck), .rspOut(rspOut),
    .memReq(memReq), .memOut(memOut), .memAck(memAck), .memRdata(memRdata),
    .testIdx(testIdx), .testEnd(testEnd), .runEnd(runEnd), .errCount(errCount)
  );

  initial begin
    gclk = 1'b0;
    forever #5 gclk = ~gclk;
  end

  function automatic wordT fillWord(input int i);
    logic [7:0] a;
    a = i[7:0];
    fillWord = {a ^ 8'hA5, ~a, a + 8'h3C, {a[3:0], a[7:4]}};
  endfunction

  // Memory responder with 0 to 5 cycles of ack delay
  always @(posedge gclk or negedge rstN) begin
    if (!rstN) begin
      memAck <= 1'b0;
      memRdata <= '0;
      delay <= 0;
    end else if (memReq && !memAck) begin
      if (delay == 0) begin
        memAck <= 1'b1;
        memRdata <= mem[memOut.wordAddr[7:0]];
        if (memOut.we) begin
          for (int b = 0; b < 4; b++) begin
            if (memOut.sel[b]) mem[memOut.wordAddr[7:0]][8*b +: 8] <= memOut.wdata[8*b +: 8];
          end
        end
      end else begin
        delay <= delay - 1;
      end
    end else if (!memReq && memAck) begin
      memAck <= 1'b0;
      delay <= int'($unsigned($random(delaySeed)) % 6);
    end
  end

  function automatic logic [31:0] nextRand();
    nextRand = $random(seed);
  endfunction

  task automatic failTimeout(input string what);
    $display("timeout waiting for %s", what);
    $display("CHECKS FAILED");
    $finish;
  endtask

  task automatic sendCmd(input opcodeT op, input sizeT sz, input regIdxT rd,
                         input regIdxT ra, input regIdxT rb, input logic [31:0] addr);
    cmdT c;
    int  n;
    logic [31:0] r;
    r = nextRand();
    c = '{opcode: op, size: sz, rd: rd, ra: ra, rb: rb, addr: addr,
          result: nextRand(), pc: r[29:0]};
    @(posedge gclk);
    cmdIn <= c;
    cmdReq <= 1'b1;
    n = 0;
    do begin
      @(negedge gclk);
      n++;
      if (n > ackTimeout) failTimeout("cmdAck high");
    end while (!cmdAck);
    @(posedge gclk);
    cmdReq <= 1'b0;
    n = 0;
    do begin
      @(negedge gclk);
      n++;
      if (n > ackTimeout) failTimeout("cmdAck low");
    end while (cmdAck);
  endtask

  // Random byte address at the given offset
  function automatic logic [31:0] alignedAddr(input logic [1:0] ofs);
    logic [31:0] r;
    r = nextRand();
    alignedAddr = {22'd0, r[7:0], ofs};
  endfunction

  task automatic finishTest(input int idx);
    @(posedge gclk);
    testIdx <= idx;
    testEnd <= 1'b1;
    @(posedge gclk);
    testEnd <= 1'b0;
  endtask

  initial begin
    logic [31:0] r;
    opcodeT op;
    sizeT sz;
    logic [1:0] ofs;
    seed = 32'h6440_a48a;
    delaySeed = seed + 1;
    for (int i = 0; i < 256; i++) mem[i] = fillWord(i);
    rstN = 1'b0;
    cmdReq = 1'b0;
    cmdIn = '0;
    testIdx = 0;
    testEnd = 1'b0;
    runEnd = 1'b0;
    repeat (2) @(posedge gclk);
    rstN <= 1'b1;
    @(posedge gclk);

    for (int i = 0; i < 32; i++) sendCmd(opAlu, szWord, 5'(i), 5'd0, 5'd0, 32'd0);
    for (int i = 0; i < 32; i++) sendCmd(opRead, szWord, 5'd0, 5'(i), 5'(31 - i), 32'd0);
    finishTest(1);

    for (int i = 0; i < 8; i++) begin
      r = nextRand();
      sendCmd(opLink, szWord, 5'(r[4:0] | 5'd1), 5'd0, 5'd0, 32'd0);
      sendCmd(opRead, szWord, 5'd0, 5'(r[4:0] | 5'd1), 5'd0, 32'd0);
    end
    finishTest(2);

    for (int s = 0; s < 3; s++) begin
      for (int o = 0; o < 4; o++) begin
        sz = sizeT'(2'(s));
        if ((sz == szByte) || (sz == szHalf && o[0] == 1'b0) || (o == 0)) begin
          r = nextRand();
          sendCmd(opStore, sz, r[4:0], 5'd0, 5'd0, alignedAddr(2'(o)));
        end
      end
    end
    finishTest(3);

    for (int s = 0; s < 3; s++) begin
      for (int o = 0; o < 4; o++) begin
        sz = sizeT'(2'(s));
        if ((sz == szByte) || (sz == szHalf && o[0] == 1'b0) || (o == 0)) begin
          r = nextRand();
          sendCmd(opLoad, sz, r[4:0], 5'd0, 5'd0, alignedAddr(2'(o)));
          sendCmd(opRead, szWord, 5'd0, r[4:0], r[9:5], 32'd0);
        end
      end
    end
    finishTest(4);

    for (int i = 0; i < 400; i++) begin
      r = nextRand();
      op = opcodeT'(3'(r[15:0] % 16'd5));
      sz = sizeT'(2'(r[23:16] % 8'd3));
      ofs = (sz == szByte) ? r[25:24] : (sz == szHalf) ? {r[24], 1'b0} : 2'b00;
      sendCmd(op, sz, r[4:0], r[9:5], r[14:10], alignedAddr(ofs));
    end
    finishTest(5);

    @(posedge gclk);
    runEnd <= 1'b1;
    @(posedge gclk);
    runEnd <= 1'b0;
    @(negedge gclk);
    if (errCount == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
src/regPkg.sv
src/opPkg.sv
src/regFileBank.sv
src/regFile.sv
src/memPort.sv
src/cmdSequencer.sv
src/dataPathTop.sv
test/tbChecker.sv
test/tbTop.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the dataPathTop testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module tbTop -f flist.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/VtbTop)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^ALL CHECKS PASSED$"; then
  exit 0
fi
exit 1
